// ==== hw/pixelColourer.sv ====
`timescale 1ns/1ps

`include "tankGame_defines.svh"

module pixelColourer
    import tankGamePkg::*;
(
    input  logic     Master_Clock_In,
    input  logic     arstN,
    input  logic     dispEna,
    // Raster point being drawn this cycle
    input  pixelPosT pixel,
    // Tank top-left corner
    input  pixelPosT tankPos,
    // Tile under the raster point
    input  tileCodeT tileCode,
    // Registered colour, one cycle behind the inputs
    output rgbT      colour
);

    ////////////////////////////////////////////////////////////
    // Tank box
    ////////////////////////////////////////////////////////////

    localparam logic [`COORD_WIDTH-1:0] TANK_SPAN = `COORD_WIDTH'(`TANK_WIDTH);

    // Far edges, both inclusive
    logic [`COORD_WIDTH-1:0] tankRight;
    logic [`COORD_WIDTH-1:0] tankBottom;
    logic inTank;
    logic outsideArea;
    rgbT  nextColour;

    // Flat colour per tile class
    function automatic rgbT tileColour(input tileCodeT code);
        rgbT result;
        case (code)
            TILE_EMPTY:
                result = `COLOUR_EMPTY;
            TILE_SOLID_A, TILE_SOLID_B:
                result = `COLOUR_SOLID;
            TILE_PATH:
                result = `COLOUR_PATH;
            TILE_HAZARD_A, TILE_HAZARD_B, TILE_HAZARD_C, TILE_HAZARD_D:
                result = `COLOUR_HAZARD;
            default:
                result = `COLOUR_UNKNOWN;
        endcase
        return result;
    endfunction

    assign tankRight = tankPos.row + TANK_SPAN;
    assign tankBottom = tankPos.col + TANK_SPAN;

    assign inTank = (pixel.row >= tankPos.row) && (pixel.row <= tankRight)
        && (pixel.col >= tankPos.col) && (pixel.col <= tankBottom);

    // Row 640 and col 480 still count as inside
    assign outsideArea = (pixel.row > `COORD_WIDTH'(`SCREEN_WIDTH))
        || (pixel.col > `COORD_WIDTH'(`SCREEN_HEIGHT));

    ////////////////////////////////////////////////////////////
    // Colour select and output register
    ////////////////////////////////////////////////////////////

    // Blanking first, then border, then tank over the map
    always_comb
    begin
        if (!dispEna)
            nextColour = '0;
        else if (outsideArea)
            nextColour = `COLOUR_OUTSIDE;
        else if (inTank)
            nextColour = `COLOUR_TANK;
        else
            nextColour = tileColour(tileCode);
    end

    always_ff @(posedge Master_Clock_In or negedge arstN)
    begin
        if (!arstN)
            colour <= '0;
        else
            colour <= nextColour;
    end

    // Blanking reaches the pins one clock later
    blankIsBlack: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
        !dispEna |=> (colour == '0));

endmodule

// ==== hw/tankGamePkg.sv ====
package tankGamePkg;

    `include "tankGame_defines.svh"

    // Screen point or tank position
    // Row runs horizontally, col runs vertically
    typedef struct packed {
        logic [`COORD_WIDTH-1:0] row;
        logic [`COORD_WIDTH-1:0] col;
    } pixelPosT;

    // Direction buttons, one bit each
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } joyStickT;

    // Output colour, 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbT;

    // Tile codes, values 8 and up are unknown
    typedef enum logic [3:0] {
        TILE_EMPTY    = 4'h0,
        TILE_SOLID_A  = 4'h1,
        TILE_SOLID_B  = 4'h2,
        TILE_PATH     = 4'h3,
        TILE_HAZARD_A = 4'h4,
        TILE_HAZARD_B = 4'h5,
        TILE_HAZARD_C = 4'h6,
        TILE_HAZARD_D = 4'h7
    } tileCodeT;

    // One map row, column 0 in the top nibble
    typedef logic [0:`MAP_COLUMNS-1][3:0] mapRowT;

    ////////////////////////////////////////////////////////////
    // Fixed level layout
    ////////////////////////////////////////////////////////////

    // Brick rows 5 to 13, open border top, bottom and sides
    localparam mapRowT mapLayout [`MAP_ROWS] = '{
        80'h0000_0000_0000_0000_0000, 80'h0000_0000_0000_0000_0000,
        80'h0000_0000_0000_0000_0000, 80'h0000_0000_0000_0000_0000,
        80'h0000_0000_0000_0000_0000, 80'h0232_3223_2222_3223_2330,
        80'h0333_3333_3333_3333_3330, 80'h0222_2232_2222_2322_2220,
        80'h0333_3333_3333_3333_3330, 80'h0232_3223_2222_3223_2320,
        80'h0332_3333_2332_3333_2330, 80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330, 80'h0232_3223_2332_3223_2320,
        80'h0000_0000_0000_0000_0000
    };

endpackage

// ==== hw/tankGameTop.sv ====
`timescale 1ns/1ps

module tankGameTop
    import tankGamePkg::*;
(
    input  logic     Master_Clock_In,
    input  logic     arstN,
    // High while the raster is in the visible region
    input  logic     dispEna,
    // Point presented this cycle, one per clock
    input  pixelPosT pixel,
    input  joyStickT buttons,
    output rgbT      colour
);

    ////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////

    // Tank corner, updated once per frame
    pixelPosT tankPos;

    // Tile under the raster point
    tileCodeT pixelTile;

    // Position register with its own corner lookups
    tankMotion motionUnit (
        .Master_Clock_In(Master_Clock_In),
        .arstN(arstN),
        .dispEna(dispEna),
        .pixel(pixel),
        .buttons(buttons),
        .tankPos(tankPos)
    );

    // Map lookup for the raster point
    tileMapRom pixelTileRom (
        .point(pixel),
        .tileCode(pixelTile)
    );

    // Colour picks up the old position on the frame-end edge
    pixelColourer colourUnit (
        .Master_Clock_In(Master_Clock_In),
        .arstN(arstN),
        .dispEna(dispEna),
        .pixel(pixel),
        .tankPos(tankPos),
        .tileCode(pixelTile),
        .colour(colour)
    );

endmodule

// ==== hw/tankGame_defines.svh ====
`ifndef TANKGAME_DEFINES_SVH
`define TANKGAME_DEFINES_SVH

////////////////////////////////////////////////////////////
// Display geometry
////////////////////////////////////////////////////////////

// Visible area in pixels
`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

// Every coordinate on the raster and for the tank
`define COORD_WIDTH 10

////////////////////////////////////////////////////////////
// Tank and tile map
////////////////////////////////////////////////////////////

// Tank box spans position to position plus this, both ends drawn
`define TANK_WIDTH 25

// Tiles are 32 pixels on a side
`define TILE_SHIFT 5
`define MAP_COLUMNS 20
`define MAP_ROWS 15

// Position loaded on reset
`define TANK_START_X 5
`define TANK_START_Y 5

////////////////////////////////////////////////////////////
// Colours as 12-bit words, red in the top nibble
////////////////////////////////////////////////////////////

`define COLOUR_EMPTY 12'hFEE
`define COLOUR_SOLID 12'h931
`define COLOUR_PATH 12'hFF0
`define COLOUR_HAZARD 12'hF44
`define COLOUR_UNKNOWN 12'h888
`define COLOUR_TANK 12'h262
`define COLOUR_OUTSIDE 12'h222

`endif

// ==== hw/tankMotion.sv ====
`timescale 1ns/1ps

`include "tankGame_defines.svh"

module tankMotion
    import tankGamePkg::*;
(
    input  logic     Master_Clock_In,
    input  logic     arstN,
    input  logic     dispEna,
    // Raster point, used only to spot the frame end
    input  pixelPosT pixel,
    input  joyStickT buttons,
    // Top-left corner of the tank box
    output pixelPosT tankPos
);

    ////////////////////////////////////////////////////////////
    // Limits
    ////////////////////////////////////////////////////////////

    // Far edge of the tank box relative to its position
    localparam logic [`COORD_WIDTH-1:0] TANK_SPAN = `COORD_WIDTH'(`TANK_WIDTH);

    // One pixel of movement per frame
    localparam logic [`COORD_WIDTH-1:0] ONE_STEP = `COORD_WIDTH'(1);

    // Highest legal position on each axis, 615 and 455
    localparam logic [`COORD_WIDTH-1:0] MAX_ROW = `COORD_WIDTH'(`SCREEN_WIDTH - `TANK_WIDTH);
    localparam logic [`COORD_WIDTH-1:0] MAX_COL = `COORD_WIDTH'(`SCREEN_HEIGHT - `TANK_WIDTH);

    // Re-entry point after leaving through the near edge
    localparam logic [`COORD_WIDTH-1:0] WRAP_ROW = MAX_ROW - ONE_STEP;
    localparam logic [`COORD_WIDTH-1:0] WRAP_COL = MAX_COL - ONE_STEP;

    logic frameEnd;

    // Position after the edge wrap
    logic [`COORD_WIDTH-1:0] wrapRow;
    logic [`COORD_WIDTH-1:0] wrapCol;
    logic [`COORD_WIDTH-1:0] farRow;
    logic [`COORD_WIDTH-1:0] farCol;
    pixelPosT nextPos;

    // Tank corners and the tiles under them
    pixelPosT topLeft;
    pixelPosT topRight;
    pixelPosT bottomLeft;
    pixelPosT bottomRight;
    tileCodeT topLeftCode;
    tileCodeT topRightCode;
    tileCodeT bottomLeftCode;
    tileCodeT bottomRightCode;
    logic topLeftSolid;
    logic topRightSolid;
    logic bottomLeftSolid;
    logic bottomRightSolid;

    // Bricks are the only tiles that block the tank
    function automatic logic isSolid(input tileCodeT code);
        return (code == TILE_SOLID_A) || (code == TILE_SOLID_B);
    endfunction

    // One update per frame, on the pixel just past the bottom-right corner
    assign frameEnd = dispEna && (pixel.row == `COORD_WIDTH'(`SCREEN_WIDTH))
        && (pixel.col == `COORD_WIDTH'(`SCREEN_HEIGHT));

    ////////////////////////////////////////////////////////////
    // Rule 1, edge wrap
    ////////////////////////////////////////////////////////////

    assign wrapRow = (tankPos.row == '0) ? WRAP_ROW :
                     (tankPos.row == MAX_ROW) ? `COORD_WIDTH'(1) : tankPos.row;
    assign wrapCol = (tankPos.col == '0) ? WRAP_COL :
                     (tankPos.col == MAX_COL) ? `COORD_WIDTH'(1) : tankPos.col;

    // Corners are sampled at the wrapped position
    assign farRow = wrapRow + TANK_SPAN;
    assign farCol = wrapCol + TANK_SPAN;
    assign topLeft = '{row: wrapRow, col: wrapCol};
    assign topRight = '{row: farRow, col: wrapCol};
    assign bottomLeft = '{row: wrapRow, col: farCol};
    assign bottomRight = '{row: farRow, col: farCol};

    tileMapRom topLeftRom (.point(topLeft), .tileCode(topLeftCode));
    tileMapRom topRightRom (.point(topRight), .tileCode(topRightCode));
    tileMapRom bottomLeftRom (.point(bottomLeft), .tileCode(bottomLeftCode));
    tileMapRom bottomRightRom (.point(bottomRight), .tileCode(bottomRightCode));

    assign topLeftSolid = isSolid(topLeftCode);
    assign topRightSolid = isSolid(topRightCode);
    assign bottomLeftSolid = isSolid(bottomLeftCode);
    assign bottomRightSolid = isSolid(bottomRightCode);

    ////////////////////////////////////////////////////////////
    // Rule 2, push-back out of bricks or button move
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        nextPos = '{row: wrapRow, col: wrapCol};
        // Whole edge in a brick, step straight away from it
        if (bottomLeftSolid && bottomRightSolid)
            nextPos.col = wrapCol - ONE_STEP;
        else if (topLeftSolid && bottomLeftSolid)
            nextPos.row = wrapRow + ONE_STEP;
        else if (topLeftSolid && topRightSolid)
            nextPos.col = wrapCol + ONE_STEP;
        else if (topRightSolid && bottomRightSolid)
            nextPos.row = wrapRow - ONE_STEP;
        // Single corner in a brick, step diagonally away
        else if (topLeftSolid)
            nextPos = '{row: wrapRow + ONE_STEP, col: wrapCol + ONE_STEP};
        else if (topRightSolid)
            nextPos = '{row: wrapRow - ONE_STEP, col: wrapCol + ONE_STEP};
        else if (bottomLeftSolid)
            nextPos = '{row: wrapRow + ONE_STEP, col: wrapCol - ONE_STEP};
        else if (bottomRightSolid)
            nextPos = '{row: wrapRow - ONE_STEP, col: wrapCol - ONE_STEP};
        // Free to move, up wins over right, down and left
        else if (buttons.up)
            nextPos.col = wrapCol - ONE_STEP;
        else if (buttons.right)
            nextPos.row = wrapRow + ONE_STEP;
        else if (buttons.down)
            nextPos.col = wrapCol + ONE_STEP;
        else if (buttons.left)
            nextPos.row = wrapRow - ONE_STEP;
    end

    always_ff @(posedge Master_Clock_In or negedge arstN)
    begin
        if (!arstN)
            tankPos <= '{row: `COORD_WIDTH'(`TANK_START_X), col: `COORD_WIDTH'(`TANK_START_Y)};
        else if (frameEnd)
            tankPos <= nextPos;
    end

    // Wrap plus one step keeps the box on screen
    positionInRange: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
        (tankPos.row <= MAX_ROW) && (tankPos.col <= MAX_COL));

    // The tank is still between frame-end events
    stillMidFrame: assert property (@(posedge Master_Clock_In) disable iff (!arstN)
        !frameEnd |=> $stable(tankPos));

endmodule

// ==== hw/tileMapRom.sv ====
`timescale 1ns/1ps

`include "tankGame_defines.svh"

module tileMapRom
    import tankGamePkg::*;
(
    // Screen point to look up
    input  pixelPosT point,
    // Code of the tile under that point
    output tileCodeT tileCode
);

    ////////////////////////////////////////////////////////////
    // Tile index arithmetic
    ////////////////////////////////////////////////////////////

    // Bits left after dropping the pixel offset inside a tile
    localparam int INDEX_WIDTH = `COORD_WIDTH - `TILE_SHIFT;

    // Width of an index into the row table
    localparam int ROW_INDEX_WIDTH = $clog2(`MAP_ROWS);

    // Map extent in index width
    localparam logic [INDEX_WIDTH-1:0] COLUMN_COUNT = INDEX_WIDTH'(`MAP_COLUMNS);
    localparam logic [INDEX_WIDTH-1:0] ROW_COUNT = INDEX_WIDTH'(`MAP_ROWS);

    // Coarse tile coordinates before folding into the map
    logic [INDEX_WIDTH-1:0] coarseColumn;
    logic [INDEX_WIDTH-1:0] coarseRow;

    // Folded indices into mapLayout
    logic [INDEX_WIDTH-1:0] tileColumn;
    logic [ROW_INDEX_WIDTH-1:0] tileRow;

    // Raw nibble from the layout table
    logic [3:0] rawCode;

    // Horizontal coordinate picks the map column
    assign coarseColumn = point.row[`COORD_WIDTH-1:`TILE_SHIFT];

    // Vertical coordinate picks the map row
    assign coarseRow = point.col[`COORD_WIDTH-1:`TILE_SHIFT];

    // Points past the map edge fold back into it
    // Columns 20 to 31 map onto 0 to 11, rows 15 to 29 onto 0 to 14, rows 30 and 31 onto 0 and 1
    assign tileColumn = coarseColumn % COLUMN_COUNT;
    assign tileRow = ROW_INDEX_WIDTH'(coarseRow % ROW_COUNT);

    ////////////////////////////////////////////////////////////
    // Layout lookup
    ////////////////////////////////////////////////////////////

    // Pure table read, no clock involved
    assign rawCode = mapLayout[tileRow][tileColumn];

    // Nibbles outside the named codes pass through unchanged
    assign tileCode = tileCodeT'(rawCode);

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build and run the tank game testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="TEST RESULT: FAIL"

verilator --binary --assert --top-module tankGameTb -f vlog.f -o tankGameSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tankGameSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_TEXT" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

echo "No failure found in $LOG"
exit 0

// ==== verif/clockGen.sv ====
`timescale 1ns/1ps

module clockGen
(
    output logic Master_Clock_In,
    output logic arstN
);

    // 100 ns clock period
    localparam int HALF_PERIOD = 50;

    // Reset length in rising edges
    localparam int RESET_CYCLES = 10;

    // Free-running clock, low at time zero
    initial
    begin
        Master_Clock_In = 1'b0;
        forever #HALF_PERIOD Master_Clock_In = ~Master_Clock_In;
    end

    // Clean falling edge shortly after start, released just after an edge
    initial
    begin
        arstN = 1'b1;
        #1;
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge Master_Clock_In);
        #5;
        arstN = 1'b1;
    end

endmodule

// ==== verif/tankGameTb.sv ====
`timescale 1ns/1ps

`include "tankGame_defines.svh"

module tankGameTb
    import tankGamePkg::*;
();

    ////////////////////////////////////////////////////////////
    // Run length and geometry
    ////////////////////////////////////////////////////////////

    // Tests take roughly this many clocks
    localparam int TEST_CYCLES = 5000;
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;
    localparam int SPAN = `TANK_WIDTH;
    localparam int COORD_MASK = (1 << `COORD_WIDTH) - 1;

    logic     Master_Clock_In;
    logic     arstN;
    logic     dispEna;
    pixelPosT pixel;
    joyStickT buttons;
    rgbT      colour;

    // Expected colour travels one clock with its pixel
    logic        probe;
    logic [11:0] expColour;
    logic        checkArm;
    logic [11:0] checkExp;

    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    logic [31:0] rngState = 32'd49;

    // Reference tank position
    int modelRow;
    int modelCol;

    clockGen clocks (
        .Master_Clock_In(Master_Clock_In),
        .arstN(arstN)
    );

    tankGameTop DUT (
        .Master_Clock_In(Master_Clock_In),
        .arstN(arstN),
        .dispEna(dispEna),
        .pixel(pixel),
        .buttons(buttons),
        .colour(colour)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // 32-bit xorshift
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Horizontal picks the map column, vertical the map row
    function automatic logic [3:0] tileCodeAt(input int row, input int col);
        logic [3:0] mapRow;
        logic [4:0] mapColumn;
        mapRow = 4'((col >> `TILE_SHIFT) % `MAP_ROWS);
        mapColumn = 5'((row >> `TILE_SHIFT) % `MAP_COLUMNS);
        return mapLayout[mapRow][mapColumn];
    endfunction

    function automatic logic solidAt(input int row, input int col);
        logic [3:0] code;
        code = tileCodeAt(row, col);
        return (code == 4'd1) || (code == 4'd2);
    endfunction

    function automatic logic [11:0] tileColourOf(input logic [3:0] code);
        if (code == 4'd0)
            return `COLOUR_EMPTY;
        else if (code <= 4'd2)
            return `COLOUR_SOLID;
        else if (code == 4'd3)
            return `COLOUR_PATH;
        else if (code <= 4'd7)
            return `COLOUR_HAZARD;
        else
            return `COLOUR_UNKNOWN;
    endfunction

    // Blanking, border, tank box, then tile
    function automatic logic [11:0] modelColour(input logic ena, input int row, input int col);
        logic inTank;
        inTank = (row >= modelRow) && (row <= modelRow + SPAN)
            && (col >= modelCol) && (col <= modelCol + SPAN);
        if (!ena)
            return 12'h000;
        else if ((row > `SCREEN_WIDTH) || (col > `SCREEN_HEIGHT))
            return `COLOUR_OUTSIDE;
        else if (inTank)
            return `COLOUR_TANK;
        else
            return tileColourOf(tileCodeAt(row, col));
    endfunction

    // Frame-end update: wrap, push-back, else buttons
    function automatic void stepModel();
        int r;
        int c;
        logic tl;
        logic tr;
        logic bl;
        logic br;
        r = modelRow;
        c = modelCol;
        if (c == 0)
            c = 454;
        else if (c == 455)
            c = 1;
        if (r == 0)
            r = 614;
        else if (r == 615)
            r = 1;
        // Corners at the wrapped position
        tl = solidAt(r, c);
        tr = solidAt(r + SPAN, c);
        bl = solidAt(r, c + SPAN);
        br = solidAt(r + SPAN, c + SPAN);
        if (bl && br)
            c = c - 1;
        else if (tl && bl)
            r = r + 1;
        else if (tl && tr)
            c = c + 1;
        else if (tr && br)
            r = r - 1;
        else if (tl)
        begin
            r = r + 1;
            c = c + 1;
        end
        else if (tr)
        begin
            r = r - 1;
            c = c + 1;
        end
        else if (bl)
        begin
            r = r + 1;
            c = c - 1;
        end
        else if (br)
        begin
            r = r - 1;
            c = c - 1;
        end
        else if (buttons.up)
            c = c - 1;
        else if (buttons.right)
            r = r + 1;
        else if (buttons.down)
            c = c + 1;
        else if (buttons.left)
            r = r - 1;
        modelRow = r;
        modelCol = c;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    // One pixel per clock, 5 ns after the edge
    task automatic presentPixel(input logic ena, input int row, input int col,
                                input logic [11:0] expected);
        @(posedge Master_Clock_In);
        #5;
        dispEna = ena;
        pixel.row = `COORD_WIDTH'(row);
        pixel.col = `COORD_WIDTH'(col);
        expColour = expected;
        probe = 1'b1;
        // Position moves on the edge that samples this pixel
        if (ena && (row == `SCREEN_WIDTH) && (col == `SCREEN_HEIGHT))
            stepModel();
    endtask

    // Expected value from the model, coordinates folded to 10 bits
    task automatic samplePixel(input logic ena, input int row, input int col);
        int maskedRow;
        int maskedCol;
        maskedRow = row & COORD_MASK;
        maskedCol = col & COORD_MASK;
        presentPixel(ena, maskedRow, maskedCol, modelColour(ena, maskedRow, maskedCol));
    endtask

    // Frame-end pixel, then a blank one so the event is not repeated
    task automatic frameEvent();
        samplePixel(1'b1, `SCREEN_WIDTH, `SCREEN_HEIGHT);
        samplePixel(1'b0, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Checkers
    ////////////////////////////////////////////////////////////

    always @(posedge Master_Clock_In)
    begin
        checkArm <= probe;
        checkExp <= expColour;
    end

    always @(negedge Master_Clock_In)
    begin
        if (arstN && checkArm)
            checkCount = checkCount + 1;
    end

    // Mid-cycle, one clock after the pixel was sampled
    colourCheck: assert property (@(negedge Master_Clock_In) disable iff (!arstN)
        checkArm |-> (colour == checkExp))
    else
    begin
        errorCount = errorCount + 1;
        $display("[ERROR] %0t colour expected %h actual %h", $time, checkExp, colour);
    end

    // Output register cleared while in reset
    resetClear: assert property (@(negedge Master_Clock_In) !arstN |-> (colour == 12'h000))
    else
    begin
        errorCount = errorCount + 1;
        $display("[ERROR] %0t colour expected %h actual %h", $time, 12'h000, colour);
    end

    always @(posedge Master_Clock_In)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        int i;
        int r;
        int c;
        logic [31:0] rnd;
        dispEna = 1'b0;
        pixel = '0;
        buttons = '0;
        probe = 1'b0;
        expColour = '0;
        modelRow = `TANK_START_X;
        modelCol = `TANK_START_Y;
        wait (arstN === 1'b0);
        wait (arstN === 1'b1);

        // Reset state and start position
        presentPixel(1'b0, 0, 0, 12'h000);
        presentPixel(1'b0, 0, 0, 12'h000);
        presentPixel(1'b1, 5, 5, `COLOUR_TANK);
        presentPixel(1'b1, 30, 30, `COLOUR_TANK);
        presentPixel(1'b1, 4, 5, `COLOUR_EMPTY);
        presentPixel(1'b1, 31, 30, `COLOUR_EMPTY);

        // Blanking
        for (i = 0; i < 20; i++)
            samplePixel(1'b0, nextRandom() % 1024, nextRandom() % 1024);

        // Border beyond the drawing area
        for (i = 0; i < 40; i++)
        begin
            rnd = nextRandom();
            if (rnd[0])
                samplePixel(1'b1, 641 + (nextRandom() % 383), nextRandom() % 1024);
            else
                samplePixel(1'b1, nextRandom() % 641, 481 + (nextRandom() % 543));
        end

        // Tile colours across the map
        for (i = 0; i < 200; i++)
            samplePixel(1'b1, nextRandom() % 641, nextRandom() % 481);

        // Left edge wrap
        buttons = '{up: 1'b0, down: 1'b0, left: 1'b1, right: 1'b0};
        repeat (5) frameEvent();
        presentPixel(1'b1, 0, 5, `COLOUR_TANK);
        presentPixel(1'b1, 26, 5, `COLOUR_EMPTY);
        frameEvent();
        presentPixel(1'b1, 613, 5, `COLOUR_TANK);
        presentPixel(1'b1, 612, 5, `COLOUR_EMPTY);

        // Random walk through the brick rows
        for (i = 0; i < 300; i++)
        begin
            rnd = nextRandom();
            buttons = joyStickT'(rnd[3:0]);
            frameEvent();
            r = modelRow;
            c = modelCol;
            samplePixel(1'b1, r, c);
            samplePixel(1'b1, r + SPAN, c);
            samplePixel(1'b1, r, c + SPAN);
            samplePixel(1'b1, r + SPAN, c + SPAN);
            // Just outside each corner
            samplePixel(1'b1, r - 1, c - 1);
            samplePixel(1'b1, r + SPAN + 1, c - 1);
            samplePixel(1'b1, r - 1, c + SPAN + 1);
            samplePixel(1'b1, r + SPAN + 1, c + SPAN + 1);
        end

        // Let the last armed check run
        @(posedge Master_Clock_In);
        #5;
        probe = 1'b0;
        repeat (2) @(negedge Master_Clock_In);

        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/tankGamePkg.sv
hw/tileMapRom.sv
hw/tankMotion.sv
hw/pixelColourer.sv
hw/tankGameTop.sv
verif/clockGen.sv
verif/tankGameTb.sv
